// File: common/dataflow_cfg.svh
// dataflow build constants
// widths and counts shared by the steering circuit and its testbench

`ifndef DATAFLOW_CFG_SVH
`define DATAFLOW_CFG_SVH

// ------------------------------
// token payload
// ------------------------------

// one data word per token
`define DF_DATA_W 32

// ------------------------------
// node fan-in and fan-out
// ------------------------------

// data sources seen by the mux
`define DF_MUX_INPUTS 2
// copies made by the eager fork
`define DF_FORK_OUTPUTS 2

`endif

// File: common/dataflow_pkg.sv
// dataflow stream types
// forward halves of the valid/ready channels between nodes

`default_nettype none

`include "dataflow_cfg.svh"

package dataflow_pkg;

	// token payload word
	typedef logic [`DF_DATA_W-1:0] data_t;

	// data stream, ready runs separately against it
	typedef struct packed {
		logic  valid;
		data_t data;
	} chan_t;

	// one-bit control stream
	// used for mux select and branch route
	typedef struct packed {
		logic valid;
		logic flag;
	} flag_chan_t;

endpackage

`default_nettype wire

// File: hdl/tail_buffer.sv
// tail buffer with one transparent slot
// passes tokens through and parks one while the consumer stalls

`timescale 1ns/10ps
`default_nettype none

module tail_buffer (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire dataflow_pkg::chan_t  in,
	output logic                      in_ready,
	output dataflow_pkg::chan_t       out,
	input  wire logic                 out_ready
);

	logic                full;
	logic                capture;
	dataflow_pkg::data_t data_q;

	// ready toward producer only depends on our own state
	// this is what cuts the combinational ready path
	assign in_ready = ~full;

	// park the token when it is offered but not taken
	assign capture = in.valid & ~full & ~out_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			full <= 1'b0;
		end else begin
			// stays full until the consumer finally takes the parked token
			full <= out.valid & ~out_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			data_q <= in.data;
		end
	end

	// empty slot means zero latency bypass
	assign out.valid = in.valid | full;
	assign out.data  = full ? data_q : in.data;

	// a stalled token stays on the output, bypassed or parked
	a_stall_hold: assert property (
		@(posedge clk) disable iff (rst)
		out.valid && !out_ready |=> out.valid && $stable(out.data)
	);

endmodule

`default_nettype wire

// File: hdl/elastic_buffer.sv
// two-slot elastic buffer
// tail buffer for the ready path, registered output stage for the data path

`timescale 1ns/10ps
`default_nettype none

module elastic_buffer (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire dataflow_pkg::chan_t  in,
	output logic                      in_ready,
	output dataflow_pkg::chan_t       out,
	input  wire logic                 out_ready
);

	// tail buffer to output stage
	dataflow_pkg::chan_t mid;
	logic                mid_ready;

	// output stage state
	logic                valid_q;
	dataflow_pkg::data_t data_q;

	tail_buffer tail0 (
		.clk       (clk),
		.rst       (rst),
		.in        (in),
		.in_ready  (in_ready),
		.out       (mid),
		.out_ready (mid_ready)
	);

	// ------------------------------
	// output stage
	// ------------------------------

	// can load when empty or when the held token leaves this cycle
	assign mid_ready = out_ready | ~valid_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			// keep the token while stalled, else take whatever is offered
			valid_q <= mid.valid | ~mid_ready;
		end
	end

	always_ff @(posedge clk) begin
		if (mid.valid & mid_ready) begin
			data_q <= mid.data;
		end
	end

	assign out.valid = valid_q;
	assign out.data  = data_q;

	// a stalled token must be held as is
	a_out_hold: assert property (
		@(posedge clk) disable iff (rst)
		out.valid && !out_ready |=> out.valid && $stable(out.data)
	);

endmodule

`default_nettype wire

// File: hdl/eager_fork.sv
// eager fork
// hands one token to several consumers, each one taking it on its own

`timescale 1ns/10ps
`default_nettype none

`include "dataflow_cfg.svh"

module eager_fork #(
	parameter int OUTPUTS = `DF_FORK_OUTPUTS
) (
	input  wire logic                               clk,
	input  wire logic                               rst,
	input  wire dataflow_pkg::chan_t                in,
	output logic                                    in_ready,
	output dataflow_pkg::chan_t [OUTPUTS-1:0]       out,
	input  wire logic [OUTPUTS-1:0]                 out_ready
);

	// set = copy not yet handed over for the current token
	logic [OUTPUTS-1:0] pending;
	// copy still owed and its consumer stalls
	logic [OUTPUTS-1:0] blocked;
	logic               fork_stop;

	always_comb begin
		for (int i = 0; i < OUTPUTS; i++) begin
			blocked[i]    = pending[i] & ~out_ready[i];
			out[i].valid  = pending[i] & in.valid;
			// every copy carries the same word
			out[i].data   = in.data;
		end
	end

	// any owed copy holds the input
	assign fork_stop = |blocked;
	assign in_ready  = ~fork_stop;

	// ------------------------------
	// per-copy pending flops
	// ------------------------------

	genvar g;
	generate
		for (g = 0; g < OUTPUTS; g++) begin : g_copy
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					pending[g] <= 1'b1;
				end else begin
					// cleared once taken while the token still waits on others
					// all set again when the input token completes
					pending[g] <= blocked[g] | ~(in.valid & fork_stop);
				end
			end

			// a copy taken early must not show up again for the same token
			a_single_copy: assert property (
				@(posedge clk) disable iff (rst)
				out[g].valid && out_ready[g] && !in_ready |=> !out[g].valid
			);
		end
	endgenerate

endmodule

`default_nettype wire

// File: hdl/mux_node.sv
// select-driven mux node
// one select token picks one source token, result goes through a tail buffer

`timescale 1ns/10ps
`default_nettype none

`include "dataflow_cfg.svh"

module mux_node #(
	parameter int INPUTS = `DF_MUX_INPUTS
) (
	input  wire logic                              clk,
	input  wire logic                              rst,
	input  wire dataflow_pkg::chan_t [INPUTS-1:0]  src,
	output logic [INPUTS-1:0]                      src_ready,
	input  wire dataflow_pkg::flag_chan_t          sel,
	output logic                                   sel_ready,
	output dataflow_pkg::chan_t                    out,
	input  wire logic                              out_ready
);

	// chosen token toward the tail buffer
	dataflow_pkg::chan_t pick;
	logic                pick_ready;

	// ------------------------------
	// source choice
	// ------------------------------

	always_comb begin
		// default data is don't-care, keep src[0] so nothing floats
		pick.valid = 1'b0;
		pick.data  = src[0].data;

		for (int i = 0; i < INPUTS; i++) begin
			// offered only when select and the indexed source are both there
			if (sel.valid && int'(sel.flag) == i && src[i].valid) begin
				pick.valid = 1'b1;
				pick.data  = src[i].data;
			end

			// idle source sees ready high, as in the library node
			// a valid source is taken only together with its select token
			src_ready[i] = ~src[i].valid |
				(sel.valid & (int'(sel.flag) == i) & pick_ready);
		end
	end

	// select is consumed in the same cycle as the chosen source
	// ready while sel is invalid has no meaning
	assign sel_ready = ~sel.valid | (pick.valid & pick_ready);

	// ------------------------------
	// output slot
	// ------------------------------

	// breaks the ready path from the downstream buffer
	tail_buffer tail0 (
		.clk       (clk),
		.rst       (rst),
		.in        (pick),
		.in_ready  (pick_ready),
		.out       (out),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

// File: hdl/branch_node.sv
// branch node
// joins a data token with a route token and steers it to the true or false side

`timescale 1ns/10ps
`default_nettype none

module branch_node (
	input  wire dataflow_pkg::chan_t       in,
	output logic                           in_ready,
	input  wire dataflow_pkg::flag_chan_t  route,
	output logic                           route_ready,
	output dataflow_pkg::chan_t            out_t,
	input  wire logic                      out_t_ready,
	output dataflow_pkg::chan_t            out_f,
	input  wire logic                      out_f_ready
);

	// joined pair of data and route
	logic join_valid;
	logic join_ready;

	// ------------------------------
	// two-input join
	// ------------------------------

	assign join_valid = in.valid & route.valid;

	// only the chosen side can stall the pair
	assign join_ready = route.flag ? out_t_ready : out_f_ready;

	// each side waits for the other before it is taken
	assign in_ready    = route.valid & join_ready;
	assign route_ready = in.valid & join_ready;

	// ------------------------------
	// steering
	// ------------------------------

	// flag 1 to the true side
	assign out_t.valid = join_valid & route.flag;
	assign out_t.data  = in.data;

	// flag 0 to the false side
	assign out_f.valid = join_valid & ~route.flag;
	assign out_f.data  = in.data;

endmodule

`default_nettype wire

// File: steer_unit/steer_unit.sv
// steering unit top level
// mux, elastic buffer, eager fork with a tap, then branch to true/false outputs

`timescale 1ns/10ps
`default_nettype none

`include "dataflow_cfg.svh"

module steer_unit (
	input  wire logic                                     clk,
	input  wire logic                                     rst,
	input  wire dataflow_pkg::chan_t [`DF_MUX_INPUTS-1:0] src,
	output logic [`DF_MUX_INPUTS-1:0]                     src_ready,
	input  wire dataflow_pkg::flag_chan_t                 sel,
	output logic                                          sel_ready,
	input  wire dataflow_pkg::flag_chan_t                 route,
	output logic                                          route_ready,
	output dataflow_pkg::chan_t                           tap,
	input  wire logic                                     tap_ready,
	output dataflow_pkg::chan_t                           out_t,
	input  wire logic                                     out_t_ready,
	output dataflow_pkg::chan_t                           out_f,
	input  wire logic                                     out_f_ready
);

	// mux to buffer
	dataflow_pkg::chan_t mux_out;
	logic                mux_ready;

	// buffer to fork
	dataflow_pkg::chan_t buf_out;
	logic                buf_ready;

	// fork copies, 0 is the tap and 1 feeds the branch
	dataflow_pkg::chan_t [`DF_FORK_OUTPUTS-1:0] fork_out;
	logic [`DF_FORK_OUTPUTS-1:0]                fork_ready;

	mux_node #(
		.INPUTS (`DF_MUX_INPUTS)
	) mux0 (
		.clk       (clk),
		.rst       (rst),
		.src       (src),
		.src_ready (src_ready),
		.sel       (sel),
		.sel_ready (sel_ready),
		.out       (mux_out),
		.out_ready (mux_ready)
	);

	elastic_buffer buf0 (
		.clk       (clk),
		.rst       (rst),
		.in        (mux_out),
		.in_ready  (mux_ready),
		.out       (buf_out),
		.out_ready (buf_ready)
	);

	eager_fork #(
		.OUTPUTS (`DF_FORK_OUTPUTS)
	) fork0 (
		.clk       (clk),
		.rst       (rst),
		.in        (buf_out),
		.in_ready  (buf_ready),
		.out       (fork_out),
		.out_ready (fork_ready)
	);

	// tap copy
	assign tap           = fork_out[0];
	assign fork_ready[0] = tap_ready;

	branch_node branch0 (
		.in          (fork_out[1]),
		.in_ready    (fork_ready[1]),
		.route       (route),
		.route_ready (route_ready),
		.out_t       (out_t),
		.out_t_ready (out_t_ready),
		.out_f       (out_f),
		.out_f_ready (out_f_ready)
	);

endmodule

`default_nettype wire

// File: verification/steer_unit_tb.sv
// steering unit testbench
// LFSR-driven valid/ready stimulus, reference queues, assertion-based checking

`timescale 1ns/10ps
`default_nettype none

`include "dataflow_cfg.svh"

module steer_unit_tb;

	// random phase, then a run of zero selects, then one select of src1
	localparam int N_RAND       = 60;
	localparam int N_HOLD       = 8;
	localparam int N_TOK        = N_RAND + N_HOLD + 1;
	localparam int STIM_LIMIT   = 4000;
	localparam int DRAIN_LIMIT  = 500;
	localparam int QUIET_CYCLES = 20;

	logic                                       clk;
	logic                                       rst;
	dataflow_pkg::chan_t [`DF_MUX_INPUTS-1:0]   src;
	logic [`DF_MUX_INPUTS-1:0]                  src_ready;
	dataflow_pkg::flag_chan_t                   sel;
	logic                                       sel_ready;
	dataflow_pkg::flag_chan_t                   route;
	logic                                       route_ready;
	dataflow_pkg::chan_t                        tap;
	logic                                       tap_ready;
	dataflow_pkg::chan_t                        out_t;
	logic                                       out_t_ready;
	dataflow_pkg::chan_t                        out_f;
	logic                                       out_f_ready;

	// reference data
	logic                sel_flags [N_TOK];
	logic                route_flags [N_TOK];
	dataflow_pkg::data_t src_tok [`DF_MUX_INPUTS][$];
	dataflow_pkg::data_t exp_tap[$];
	dataflow_pkg::data_t exp_t[$];
	dataflow_pkg::data_t exp_f[$];

	// producer progress counted in handshakes
	int src_pos [`DF_MUX_INPUTS];
	int sel_pos;
	int route_pos;
	int cyc;
	int since_rst;

	// handshakes seen at the last rising edge
	logic [`DF_MUX_INPUTS-1:0] took_src;
	logic                      took_sel;
	logic                      took_route;

	logic [15:0] lfsr;

	steer_unit dut0 (
		.clk         (clk),
		.rst         (rst),
		.src         (src),
		.src_ready   (src_ready),
		.sel         (sel),
		.sel_ready   (sel_ready),
		.route       (route),
		.route_ready (route_ready),
		.tap         (tap),
		.tap_ready   (tap_ready),
		.out_t       (out_t),
		.out_t_ready (out_t_ready),
		.out_f       (out_f),
		.out_f_ready (out_f_ready)
	);

	always #20 clk = ~clk;

	// ------------------------------
	// helpers
	// ------------------------------

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_token(input string name, input dataflow_pkg::data_t got,
			input dataflow_pkg::data_t exp);
		assert (got == exp) else
			stop_on_error($sformatf("FAILED at %0t: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else
			stop_on_error($sformatf("FAILED at %0t: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	// right-shift form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] galois_step(input logic [15:0] s);
		logic [15:0] n;
		n = {1'b0, s[15:1]};
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// one step per bit
	function logic take_bit();
		logic b;
		b    = lfsr[0];
		lfsr = galois_step(lfsr);
		return b;
	endfunction

	// source tag, sequence number, random low half
	function automatic dataflow_pkg::data_t make_token(input int s, input int n);
		dataflow_pkg::data_t t;
		t = '0;
		t[`DF_DATA_W-1 -: 4]  = s[3:0];
		t[`DF_DATA_W-5 -: 12] = n[11:0];
		for (int b = 0; b < 16; b++) begin
			t[b] = take_bit();
		end
		return t;
	endfunction

	function automatic bit producers_done();
		bit done;
		done = (sel_pos == N_TOK) && (route_pos == N_TOK);
		for (int i = 0; i < `DF_MUX_INPUTS; i++) begin
			done = done && (src_pos[i] == src_tok[i].size());
		end
		return done;
	endfunction

	// ------------------------------
	// falling-edge driver
	// ------------------------------

	task automatic drive_inputs();
		logic go;
		logic r0;
		logic r1;
		logic stall_tap;
		cyc++;
		// long tap-only stalls let the branch copy run ahead
		stall_tap = (cyc % 80) >= 60;
		for (int i = 0; i < `DF_MUX_INPUTS; i++) begin
			if (took_src[i]) begin
				src_pos[i]++;
				src[i].valid = 1'b0;
			end
			if (!src[i].valid && src_pos[i] < src_tok[i].size()) begin
				go = take_bit();
				// src1 parks its token while the zero selects pass
				if (go || (i == 1 && sel_pos >= N_RAND)) begin
					src[i].valid = 1'b1;
					src[i].data  = src_tok[i][src_pos[i]];
				end
			end
		end
		if (took_sel) begin
			sel_pos++;
			sel.valid = 1'b0;
		end
		if (!sel.valid && sel_pos < N_TOK) begin
			go = take_bit();
			if (go) begin
				sel.valid = 1'b1;
				sel.flag  = sel_flags[sel_pos];
			end
		end
		if (took_route) begin
			route_pos++;
			route.valid = 1'b0;
		end
		if (!route.valid && route_pos < N_TOK) begin
			go = take_bit();
			if (go) begin
				route.valid = 1'b1;
				route.flag  = route_flags[route_pos];
			end
		end
		// consumers ready about three cycles in four
		r0 = take_bit();
		r1 = take_bit();
		tap_ready = (r0 | r1) & ~stall_tap;
		r0 = take_bit();
		r1 = take_bit();
		out_t_ready = r0 | r1;
		r0 = take_bit();
		r1 = take_bit();
		out_f_ready = r0 | r1;
	endtask

	// ------------------------------
	// rising-edge monitor
	// ------------------------------

	always @(posedge clk) begin
		if (rst) begin
			since_rst = 0;
		end else begin
			since_rst++;
		end
		// outputs quiet in reset and the first cycle out of it
		if (since_rst <= 1) begin
			check_bit("tap.valid", tap.valid, 1'b0);
			check_bit("out_t.valid", out_t.valid, 1'b0);
			check_bit("out_f.valid", out_f.valid, 1'b0);
		end
		for (int i = 0; i < `DF_MUX_INPUTS; i++) begin
			took_src[i] = src[i].valid && src_ready[i];
		end
		took_sel   = sel.valid && sel_ready;
		took_route = route.valid && route_ready;
		if (!rst) begin
			// a source moves only together with a select naming it
			for (int i = 0; i < `DF_MUX_INPUTS; i++) begin
				if (took_src[i]) begin
					assert (took_sel && int'(sel.flag) == i) else
						stop_on_error("a source token was taken without its select");
				end
			end
			if (took_sel) begin
				assert (took_src[sel.flag]) else
					stop_on_error("a select token was taken without its source token");
			end
			if (tap.valid) begin
				assert (exp_tap.size() > 0) else
					stop_on_error("tap raised valid with no token expected");
				if (tap_ready) begin
					check_token("tap.data", tap.data, exp_tap.pop_front());
				end
			end
			if (out_t.valid) begin
				assert (exp_t.size() > 0) else
					stop_on_error("out_t raised valid with no token expected");
				if (out_t_ready) begin
					assert (took_route && route.flag) else
						stop_on_error("out_t moved without a true route token");
					check_token("out_t.data", out_t.data, exp_t.pop_front());
				end
			end
			if (out_f.valid) begin
				assert (exp_f.size() > 0) else
					stop_on_error("out_f raised valid with no token expected");
				if (out_f_ready) begin
					assert (took_route && !route.flag) else
						stop_on_error("out_f moved without a false route token");
					check_token("out_f.data", out_f.data, exp_f.pop_front());
				end
			end
		end
	end

	// stalled outputs keep valid and data
	a_tap_hold: assert property (@(posedge clk) disable iff (rst)
		tap.valid && !tap_ready |=> tap.valid && $stable(tap.data))
		else stop_on_error("tap dropped or changed its token while stalled");
	a_out_t_hold: assert property (@(posedge clk) disable iff (rst)
		out_t.valid && !out_t_ready |=> out_t.valid && $stable(out_t.data))
		else stop_on_error("out_t dropped or changed its token while stalled");
	a_out_f_hold: assert property (@(posedge clk) disable iff (rst)
		out_f.valid && !out_f_ready |=> out_f.valid && $stable(out_f.data))
		else stop_on_error("out_f dropped or changed its token while stalled");

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		bit                  fed;
		bit                  drained;
		int                  s;
		dataflow_pkg::data_t tok;
		clk         = 1'b0;
		rst         = 1'b1;
		src         = '0;
		sel         = '0;
		route       = '0;
		tap_ready   = 1'b0;
		out_t_ready = 1'b0;
		out_f_ready = 1'b0;
		took_src    = '0;
		took_sel    = 1'b0;
		took_route  = 1'b0;
		sel_pos     = 0;
		route_pos   = 0;
		cyc         = 0;
		since_rst   = 0;
		lfsr        = 16'd18;
		for (int i = 0; i < `DF_MUX_INPUTS; i++) begin
			src_pos[i] = 0;
		end
		// k-th result is the next token of the source named by the k-th select
		for (int k = 0; k < N_TOK; k++) begin
			if (k < N_RAND) begin
				sel_flags[k] = take_bit();
			end else begin
				sel_flags[k] = (k == N_TOK - 1);
			end
			route_flags[k] = take_bit();
			s   = int'(sel_flags[k]);
			tok = make_token(s, src_tok[s].size());
			src_tok[s].push_back(tok);
			exp_tap.push_back(tok);
			if (route_flags[k]) begin
				exp_t.push_back(tok);
			end else begin
				exp_f.push_back(tok);
			end
		end
		repeat (10) @(negedge clk);
		rst = 1'b0;
		fed = 1'b0;
		for (int c = 0; c < STIM_LIMIT && !fed; c++) begin
			@(negedge clk);
			drive_inputs();
			fed = producers_done();
		end
		if (!fed) begin
			stop_on_error("timeout while feeding source, select and route tokens");
		end
		drained = 1'b0;
		for (int c = 0; c < DRAIN_LIMIT && !drained; c++) begin
			@(negedge clk);
			drive_inputs();
			drained = (exp_tap.size() == 0) && (exp_t.size() == 0) && (exp_f.size() == 0);
		end
		if (drained) begin
			// any late valid now finds an empty expected queue in the monitor
			for (int c = 0; c < QUIET_CYCLES; c++) begin
				@(negedge clk);
				drive_inputs();
			end
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_on_error("timeout while draining tap, out_t and out_f");
		end
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/dataflow_pkg.sv
hdl/tail_buffer.sv
hdl/elastic_buffer.sv
hdl/eager_fork.sv
hdl/mux_node.sv
hdl/branch_node.sv
steer_unit/steer_unit.sv
verification/steer_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := steer_unit_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
